// File: hdl/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;
    localparam int REG_AW = 5;
    localparam int NUM_REGS = 32;
    localparam logic [XLEN-1:0] RESET_ADDR = 32'h0000_0000;
    localparam int SEL_W = 4;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_HALT
    } state_e;

    typedef struct packed {
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [XLEN-1:0]   imm;
        alu_op_e           alu_op;
        logic              op1_pc;
        logic              op1_zero;
        logic              op2_imm;
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
        logic              branch;
        logic              branch_ne;
        logic              jal;
        logic              illegal;
    } decoded_t;

    // Wishbone classic master request
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [XLEN-1:0]  adr;
        logic [XLEN-1:0]  dat;
        logic [SEL_W-1:0] sel;
    } wb_m2s_t;

    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] dat;
    } wb_s2m_t;

endpackage

// File: hdl/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::decoded_t        i_dec,
    input  logic [rv_pkg::XLEN-1:0] i_pc,
    input  logic [rv_pkg::XLEN-1:0] i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0] i_rs2_data,
    output logic [rv_pkg::XLEN-1:0] o_result,
    output logic                    o_take
);

    logic [rv_pkg::XLEN-1:0] op1;
    logic [rv_pkg::XLEN-1:0] op2;

    // JAL link and LUI both come out of the adder
    assign op1 = i_dec.op1_pc   ? i_pc :
                 i_dec.op1_zero ? '0   : i_rs1_data;
    assign op2 = i_dec.jal      ? rv_pkg::XLEN'(4) :
                 i_dec.op2_imm  ? i_dec.imm        : i_rs2_data;

    always_comb begin
        case (i_dec.alu_op)
            rv_pkg::ADD: o_result = op1 + op2;
            rv_pkg::SUB: o_result = op1 - op2;
            rv_pkg::AND: o_result = op1 & op2;
            rv_pkg::OR:  o_result = op1 | op2;
            rv_pkg::XOR: o_result = op1 ^ op2;
            rv_pkg::SLT: o_result = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            default:     o_result = op1 + op2;
        endcase
    end

    assign o_take = i_dec.branch & ((i_rs1_data == i_rs2_data) ^ i_dec.branch_ne);

endmodule

// File: hdl/rv_ctrl.sv
`timescale 1ns/1ps

module rv_ctrl (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_instr_valid,
    input  rv_pkg::decoded_t i_dec,
    input  logic             i_mem_done,
    output logic             o_fetch_req,
    output logic             o_pc_update,
    output logic             o_mem_req,
    output logic             o_rd_we,
    output logic             o_wb_load,
    output logic             o_halt
);

    rv_pkg::state_e state;
    rv_pkg::state_e state_next;
    logic           is_mem;
    logic           exec_done;
    logic           load_done;

    assign is_mem = i_dec.mem_read | i_dec.mem_write;

    always_comb begin
        state_next = state;
        unique case (state)
            rv_pkg::S_FETCH: begin
                if (i_instr_valid) begin
                    state_next = rv_pkg::S_EXEC;
                end
            end
            rv_pkg::S_EXEC: begin
                if (i_dec.illegal) begin
                    state_next = rv_pkg::S_HALT;
                end else if (is_mem) begin
                    state_next = rv_pkg::S_MEM;
                end else begin
                    state_next = rv_pkg::S_FETCH;
                end
            end
            rv_pkg::S_MEM: begin
                if (i_mem_done) begin
                    state_next = rv_pkg::S_FETCH;
                end
            end
            default: state_next = rv_pkg::S_HALT;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= rv_pkg::S_FETCH;
        end else begin
            state <= state_next;
        end
    end

    // Non-memory instructions retire at the end of S_EXEC, loads and stores on done
    assign exec_done = (state == rv_pkg::S_EXEC) & ~i_dec.illegal & ~is_mem;
    assign load_done = (state == rv_pkg::S_MEM) & i_mem_done;

    assign o_fetch_req = (state == rv_pkg::S_FETCH);
    assign o_mem_req   = (state == rv_pkg::S_MEM);
    assign o_pc_update = exec_done | load_done;
    assign o_rd_we     = (exec_done | load_done) & i_dec.reg_write;
    assign o_wb_load   = i_dec.mem_read;
    assign o_halt      = (state == rv_pkg::S_HALT);

    // Completion pulses only arrive in the state that waits for them
    a_valid_in_fetch: assert property (
        @(posedge i_clk) disable iff (i_rst) i_instr_valid |-> state == rv_pkg::S_FETCH
    );

    a_done_in_mem: assert property (
        @(posedge i_clk) disable iff (i_rst) i_mem_done |-> state == rv_pkg::S_MEM
    );

endmodule

// File: hdl/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic [rv_pkg::XLEN-1:0] i_instr,
    output rv_pkg::decoded_t        o_dec
);

    rv_pkg::opcode_e         opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_s;
    logic [rv_pkg::XLEN-1:0] imm_b;
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic [rv_pkg::XLEN-1:0] imm_j;

    assign opcode = rv_pkg::opcode_e'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    always_comb begin
        o_dec        = '0;
        o_dec.rd     = i_instr[11:7];
        o_dec.rs1    = i_instr[19:15];
        o_dec.rs2    = i_instr[24:20];
        o_dec.alu_op = rv_pkg::ADD;
        case (opcode)
            rv_pkg::OP: begin
                o_dec.reg_write = 1'b1;
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  o_dec.alu_op = rv_pkg::ADD;
                        3'b010:  o_dec.alu_op = rv_pkg::SLT;
                        3'b100:  o_dec.alu_op = rv_pkg::XOR;
                        3'b110:  o_dec.alu_op = rv_pkg::OR;
                        3'b111:  o_dec.alu_op = rv_pkg::AND;
                        default: o_dec.illegal = 1'b1;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    o_dec.alu_op = rv_pkg::SUB;
                end else begin
                    o_dec.illegal = 1'b1;
                end
            end
            rv_pkg::OP_IMM: begin
                // Only ADDI among the immediate forms
                o_dec.reg_write = 1'b1;
                o_dec.op2_imm   = 1'b1;
                o_dec.imm       = imm_i;
                o_dec.illegal   = (funct3 != 3'b000);
            end
            rv_pkg::LUI: begin
                o_dec.reg_write = 1'b1;
                o_dec.op1_zero  = 1'b1;
                o_dec.op2_imm   = 1'b1;
                o_dec.imm       = imm_u;
            end
            rv_pkg::LOAD: begin
                o_dec.reg_write = 1'b1;
                o_dec.mem_read  = 1'b1;
                o_dec.op2_imm   = 1'b1;
                o_dec.imm       = imm_i;
                o_dec.illegal   = (funct3 != 3'b010);
            end
            rv_pkg::STORE: begin
                o_dec.mem_write = 1'b1;
                o_dec.op2_imm   = 1'b1;
                o_dec.imm       = imm_s;
                o_dec.illegal   = (funct3 != 3'b010);
            end
            rv_pkg::BRANCH: begin
                o_dec.branch    = 1'b1;
                o_dec.branch_ne = funct3[0];
                o_dec.imm       = imm_b;
                o_dec.illegal   = (funct3[2:1] != 2'b00);
            end
            rv_pkg::JAL: begin
                o_dec.reg_write = 1'b1;
                o_dec.jal       = 1'b1;
                o_dec.op1_pc    = 1'b1;
                o_dec.imm       = imm_j;
            end
            default: o_dec.illegal = 1'b1;
        endcase
        // Illegal words must leave no side effects
        if (o_dec.illegal) begin
            o_dec.reg_write = 1'b0;
            o_dec.mem_read  = 1'b0;
            o_dec.mem_write = 1'b0;
            o_dec.branch    = 1'b0;
            o_dec.jal       = 1'b0;
        end
    end

endmodule

// File: hdl/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_fetch_req,
    input  logic                    i_pc_update,
    input  logic                    i_take,
    input  rv_pkg::decoded_t        i_dec,
    input  rv_pkg::wb_s2m_t         i_ibus,
    output rv_pkg::wb_m2s_t         o_ibus,
    output logic [rv_pkg::XLEN-1:0] o_pc,
    output logic [rv_pkg::XLEN-1:0] o_instr,
    output logic                    o_instr_valid
);

    logic [rv_pkg::XLEN-1:0] pc_next;
    logic                    cyc;

    assign pc_next = (i_dec.jal || i_take) ? o_pc + i_dec.imm
                                           : o_pc + rv_pkg::XLEN'(4);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cyc           <= 1'b0;
            o_instr_valid <= 1'b0;
            o_pc          <= rv_pkg::RESET_ADDR;
        end else begin
            o_instr_valid <= cyc & i_ibus.ack;
            if (cyc) begin
                if (i_ibus.ack) begin
                    cyc <= 1'b0;
                end
            end else if (i_fetch_req && !o_instr_valid) begin
                cyc <= 1'b1;
            end
            if (i_pc_update) begin
                o_pc <= pc_next;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (cyc && i_ibus.ack) begin
            o_instr <= i_ibus.dat;
        end
    end

    // Read-only word port
    assign o_ibus.cyc = cyc;
    assign o_ibus.stb = cyc;
    assign o_ibus.we  = 1'b0;
    assign o_ibus.adr = o_pc;
    assign o_ibus.dat = '0;
    assign o_ibus.sel = '1;

    a_pc_aligned: assert property (
        @(posedge i_clk) disable iff (i_rst) o_pc[1:0] == 2'b00
    );

endmodule

// File: hdl/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_mem_req,
    input  rv_pkg::decoded_t        i_dec,
    input  logic [rv_pkg::XLEN-1:0] i_addr,
    input  logic [rv_pkg::XLEN-1:0] i_store_data,
    input  rv_pkg::wb_s2m_t         i_dbus,
    output rv_pkg::wb_m2s_t         o_dbus,
    output logic [rv_pkg::XLEN-1:0] o_load_data,
    output logic                    o_done
);

    logic cyc;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cyc    <= 1'b0;
            o_done <= 1'b0;
        end else begin
            o_done <= cyc & i_dbus.ack;
            if (cyc) begin
                if (i_dbus.ack) begin
                    cyc <= 1'b0;
                end
            end else if (i_mem_req && !o_done) begin
                cyc <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (cyc && i_dbus.ack) begin
            o_load_data <= i_dbus.dat;
        end
    end

    // Word accesses only
    assign o_dbus.cyc = cyc;
    assign o_dbus.stb = cyc;
    assign o_dbus.we  = i_dec.mem_write;
    assign o_dbus.adr = i_addr;
    assign o_dbus.dat = i_store_data;
    assign o_dbus.sel = '1;

    // Request stays steady until the slave acks
    a_hold_until_ack: assert property (
        @(posedge i_clk) disable iff (i_rst) o_dbus.cyc && !i_dbus.ack |=> $stable(o_dbus)
    );

endmodule

// File: hdl/rv_regs.sv
`timescale 1ns/1ps

module rv_regs (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  rv_pkg::decoded_t        i_dec,
    input  logic                    i_we,
    input  logic                    i_wb_load,
    input  logic [rv_pkg::XLEN-1:0] i_alu_result,
    input  logic [rv_pkg::XLEN-1:0] i_load_data,
    output logic [rv_pkg::XLEN-1:0] o_rs1_data,
    output logic [rv_pkg::XLEN-1:0] o_rs2_data
);

    logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS];
    logic [rv_pkg::XLEN-1:0] wr_data;

    assign wr_data = i_wb_load ? i_load_data : i_alu_result;

    // x0 is never written so it keeps its reset value
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_dec.rd != '0) begin
            regs[i_dec.rd] <= wr_data;
        end
    end

    assign o_rs1_data = regs[i_dec.rs1];
    assign o_rs2_data = regs[i_dec.rs2];

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic             i_clk,
    input  logic             i_rst,
    input  rv_pkg::wb_s2m_t  i_ibus,
    output rv_pkg::wb_m2s_t  o_ibus,
    input  rv_pkg::wb_s2m_t  i_dbus,
    output rv_pkg::wb_m2s_t  o_dbus,
    output logic             o_halt
);

    rv_pkg::decoded_t          dec;
    logic [rv_pkg::XLEN-1:0]   pc;
    logic [rv_pkg::XLEN-1:0]   instr;
    logic [rv_pkg::XLEN-1:0]   alu_result;
    logic [rv_pkg::XLEN-1:0]   rs1_data;
    logic [rv_pkg::XLEN-1:0]   rs2_data;
    logic [rv_pkg::XLEN-1:0]   load_data;
    logic                      instr_valid;
    logic                      take;
    logic                      mem_done;
    logic                      fetch_req;
    logic                      pc_update;
    logic                      mem_req;
    logic                      rd_we;
    logic                      wb_load;

    rv_ctrl u_ctrl (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_instr_valid (instr_valid),
        .i_dec         (dec),
        .i_mem_done    (mem_done),
        .o_fetch_req   (fetch_req),
        .o_pc_update   (pc_update),
        .o_mem_req     (mem_req),
        .o_rd_we       (rd_we),
        .o_wb_load     (wb_load),
        .o_halt        (o_halt)
    );

    rv_fetch u_fetch (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_fetch_req   (fetch_req),
        .i_pc_update   (pc_update),
        .i_take        (take),
        .i_dec         (dec),
        .i_ibus        (i_ibus),
        .o_ibus        (o_ibus),
        .o_pc          (pc),
        .o_instr       (instr),
        .o_instr_valid (instr_valid)
    );

    rv_decode u_decode (
        .i_instr (instr),
        .o_dec   (dec)
    );

    rv_alu u_alu (
        .i_dec      (dec),
        .i_pc       (pc),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_result   (alu_result),
        .o_take     (take)
    );

    rv_regs u_regs (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_dec        (dec),
        .i_we         (rd_we),
        .i_wb_load    (wb_load),
        .i_alu_result (alu_result),
        .i_load_data  (load_data),
        .o_rs1_data   (rs1_data),
        .o_rs2_data   (rs2_data)
    );

    rv_lsu u_lsu (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_mem_req    (mem_req),
        .i_dec        (dec),
        .i_addr       (alu_result),
        .i_store_data (rs2_data),
        .i_dbus       (i_dbus),
        .o_dbus       (o_dbus),
        .o_load_data  (load_data),
        .o_done       (mem_done)
    );

endmodule

// File: sim/tb_wb_mem.sv
`timescale 1ns/1ps

module tb_wb_mem #(
    parameter int          MEM_WORDS = 256,
    parameter logic [31:0] SEED      = 32'h1
) (
    input  logic            i_clk,
    input  logic            i_rst,
    input  rv_pkg::wb_m2s_t i_ibus,
    output rv_pkg::wb_s2m_t o_ibus,
    input  rv_pkg::wb_m2s_t i_dbus,
    output rv_pkg::wb_s2m_t o_dbus
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [31:0]     mem [MEM_WORDS];
    integer          seed = SEED;
    logic [1:0]      iwait;
    logic [1:0]      dwait;
    rv_pkg::wb_s2m_t ibus_rsp = '0;
    rv_pkg::wb_s2m_t dbus_rsp = '0;

    // Each transfer counts down its wait states, then acks for one cycle
    always @(posedge i_clk) begin
        if (i_rst) begin
            ibus_rsp <= '0;
            dbus_rsp <= '0;
            iwait    <= 2'($random(seed));
            dwait    <= 2'($random(seed));
        end else begin
            if (ibus_rsp.ack) begin
                ibus_rsp.ack <= 1'b0;
                iwait        <= 2'($random(seed));
            end else if (i_ibus.cyc && i_ibus.stb) begin
                if (iwait == 2'd0) begin
                    ibus_rsp.ack <= 1'b1;
                    ibus_rsp.dat <= mem[i_ibus.adr[AW+1:2]];
                end else begin
                    iwait <= iwait - 2'd1;
                end
            end
            if (dbus_rsp.ack) begin
                dbus_rsp.ack <= 1'b0;
                dwait        <= 2'($random(seed));
            end else if (i_dbus.cyc && i_dbus.stb) begin
                if (dwait == 2'd0) begin
                    dbus_rsp.ack <= 1'b1;
                    dbus_rsp.dat <= mem[i_dbus.adr[AW+1:2]];
                    if (i_dbus.we) begin
                        mem[i_dbus.adr[AW+1:2]] = i_dbus.dat;
                    end
                end else begin
                    dwait <= dwait - 2'd1;
                end
            end
        end
    end

    assign o_ibus = ibus_rsp;
    assign o_dbus = dbus_rsp;

endmodule

// File: sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int          CLK_PERIOD = 40;
    localparam logic [31:0] RAND_SEED  = 32'hef7703ca;
    localparam int          MEM_WORDS  = 256;
    localparam int          PROG_LEN   = 26;
    localparam int          NUM_STORES = 10;
    // Worst case is fetch plus exec plus memory access, all with three wait states
    localparam int          MAX_CPI     = 16;
    localparam int          WATCHDOG_NS = (PROG_LEN * MAX_CPI + 64) * CLK_PERIOD;
    localparam int          HALT_CYCLES = 20;

    localparam logic [31:0] IMM_A    = 32'h0000_0123;
    localparam logic [31:0] LUI_B    = 32'h1234_5000;
    localparam logic [31:0] SUM      = IMM_A + LUI_B;
    localparam logic [31:0] DIFF     = IMM_A - LUI_B;
    localparam logic [31:0] SLT_VAL  = ($signed(DIFF) < $signed(IMM_A)) ? 32'd1 : 32'd0;
    localparam logic [31:0] JAL_ADDR = 32'h0000_0050;
    localparam logic [31:0] SKIP_0   = 32'h0000_01f0;
    localparam logic [31:0] SKIP_1   = 32'h0000_01f4;

    localparam logic [31:0] PROG_WORDS [PROG_LEN] = '{
        32'h12300093,  // addi x1, x0, 0x123
        32'h12345137,  // lui  x2, 0x12345
        32'h002081b3,  // add  x3, x1, x2
        32'h40208233,  // sub  x4, x1, x2
        32'h0041f2b3,  // and  x5, x3, x4
        32'h0041e333,  // or   x6, x3, x4
        32'h0041c3b3,  // xor  x7, x3, x4
        32'h00122433,  // slt  x8, x4, x1
        32'h10302023,  // sw   x3, 0x100(x0)
        32'h10402223,  // sw   x4, 0x104(x0)
        32'h10502423,  // sw   x5, 0x108(x0)
        32'h10602623,  // sw   x6, 0x10c(x0)
        32'h10702823,  // sw   x7, 0x110(x0)
        32'h10802a23,  // sw   x8, 0x114(x0)
        32'h10402483,  // lw   x9, 0x104(x0)
        32'h10902c23,  // sw   x9, 0x118(x0)
        32'h00108463,  // beq  x1, x1, +8
        32'h1e102823,  // sw   x1, 0x1f0(x0) skipped
        32'h00109463,  // bne  x1, x1, +8
        32'h10102e23,  // sw   x1, 0x11c(x0)
        32'h0080056f,  // jal  x10, +8
        32'h1e202a23,  // sw   x2, 0x1f4(x0) skipped
        32'h12a02023,  // sw   x10, 0x120(x0)
        32'h00500013,  // addi x0, x0, 5
        32'h12002223,  // sw   x0, 0x124(x0)
        32'h00000000   // illegal word, halts the core
    };

    localparam logic [31:0] EXP_ADDR [NUM_STORES] = '{
        32'h100, 32'h104, 32'h108, 32'h10c, 32'h110,
        32'h114, 32'h118, 32'h11c, 32'h120, 32'h124
    };
    localparam logic [31:0] EXP_DATA [NUM_STORES] = '{
        SUM, DIFF, SUM & DIFF, SUM | DIFF, SUM ^ DIFF,
        SLT_VAL, DIFF, IMM_A, JAL_ADDR + 32'd4, 32'd0
    };

    logic            clk;
    logic            rst;
    logic            halt;
    rv_pkg::wb_m2s_t ibus_m2s;
    rv_pkg::wb_s2m_t ibus_s2m;
    rv_pkg::wb_m2s_t dbus_m2s;
    rv_pkg::wb_s2m_t dbus_s2m;
    logic [31:0]     got_addr [$];
    logic [31:0]     got_data [$];
    time             got_time [$];
    int              errors = 0;

    rv_core u_dut (
        .i_clk  (clk),
        .i_rst  (rst),
        .i_ibus (ibus_s2m),
        .o_ibus (ibus_m2s),
        .i_dbus (dbus_s2m),
        .o_dbus (dbus_m2s),
        .o_halt (halt)
    );

    tb_wb_mem #(
        .MEM_WORDS (MEM_WORDS),
        .SEED      (RAND_SEED)
    ) u_mem (
        .i_clk  (clk),
        .i_rst  (rst),
        .i_ibus (ibus_m2s),
        .o_ibus (ibus_s2m),
        .i_dbus (dbus_m2s),
        .o_dbus (dbus_s2m)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Every completed data-bus write, in bus order
    always @(posedge clk) begin
        if (dbus_m2s.cyc && dbus_m2s.stb && dbus_m2s.we && dbus_s2m.ack) begin
            got_addr.push_back(dbus_m2s.adr);
            got_data.push_back(dbus_m2s.dat);
            got_time.push_back($time);
        end
    end

    // Word-only requests, and the instruction port never writes
    always @(posedge clk) begin
        if (ibus_s2m.ack && (ibus_m2s.we || ibus_m2s.sel != 4'hf)) begin
            errors++;
            $display("mismatch at %0t: instruction request we %b sel %h, expected we 0 sel f",
                     $time, ibus_m2s.we, ibus_m2s.sel);
        end
        if (dbus_s2m.ack && dbus_m2s.sel != 4'hf) begin
            errors++;
            $display("mismatch at %0t: data request sel %h, expected f", $time, dbus_m2s.sel);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: core did not halt within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            u_mem.mem[i] = 32'h5a5a_0000 ^ (i << 2);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            u_mem.mem[i] = PROG_WORDS[i];
        end
        repeat (3) begin
            @(negedge clk);
            if (ibus_m2s.cyc || dbus_m2s.cyc || halt) begin
                errors++;
                $display("bus cycle or halt seen during reset at %0t", $time);
            end
        end
        rst = 1'b0;

        do @(negedge clk); while (!ibus_m2s.cyc);
        if (ibus_m2s.adr != rv_pkg::RESET_ADDR) begin
            errors++;
            $display("mismatch at %0t: first fetch address %h, expected %h",
                     $time, ibus_m2s.adr, rv_pkg::RESET_ADDR);
        end

        while (!halt) @(negedge clk);
        repeat (HALT_CYCLES) begin
            @(negedge clk);
            if (!halt || ibus_m2s.cyc || dbus_m2s.cyc) begin
                errors++;
                $display("core left halt or started a bus cycle at %0t", $time);
            end
        end

        if (got_addr.size() != NUM_STORES) begin
            errors++;
            $display("collected %0d stores but %0d were expected", got_addr.size(), NUM_STORES);
        end
        for (int i = 0; i < got_addr.size(); i++) begin
            if (got_addr[i] == SKIP_0 || got_addr[i] == SKIP_1) begin
                errors++;
                $display("skipped store to %h reached the data bus", got_addr[i]);
            end else if (i < NUM_STORES) begin
                if (got_addr[i] != EXP_ADDR[i] || got_data[i] != EXP_DATA[i]) begin
                    errors++;
                    $display("mismatch at %0t: store %0d wrote %h to %h, expected %h to %h",
                             got_time[i], i, got_data[i], got_addr[i], EXP_DATA[i], EXP_ADDR[i]);
                end
            end
        end

        $display("errors: %0d, stores collected: %0d", errors, got_addr.size());
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: rv_core.f
hdl/rv_pkg.sv
hdl/rv_alu.sv
hdl/rv_ctrl.sv
hdl/rv_decode.sv
hdl/rv_fetch.sv
hdl/rv_lsu.sv
hdl/rv_regs.sv
hdl/rv_core.sv
sim/tb_wb_mem.sv
sim/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_rv_core -f rv_core.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
    exit 0
fi
exit 1
